/* src.f */
source/mmio_ep_pkg.sv
source/cbw_parser.sv
source/bulk_packet_fifo.sv
source/ep_control.sv
source/mmio_ep_top.sv
bench/mmio_ep_checker.sv
bench/mmio_ep_monitor.sv
bench/tb_mmio_ep.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_mmio_ep
FILELIST  = src.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/tb_mmio_ep.sv */
`timescale 1ns/1ps

module tb_mmio_ep;
  import mmio_ep_pkg::*;

  localparam int MPL   = 64;
  localparam int FD    = 256;
  localparam int TMO   = 2000;
  // Packet size for the data phases, small to keep frames short
  localparam int MAXSZ = 8;

  logic        clock;
  logic        rst_i;
  logic        set_conf_i;
  logic        clr_conf_i;
  logic [6:0]  max_size_i;
  logic        selected_i;
  logic        ack_sent_i;
  logic        rx_error_i;
  usb_byte_t   usb_i;
  logic        usb_ready_o;
  mmio_cmd_t   cmd_o;
  logic        cmd_vld_o;
  logic        cmd_ack_i;
  logic        mmio_sent_i;
  logic        mmio_resp_i;
  usb_byte_t   dat_o;
  logic        dat_ready_i;
  logic        ep_ready_o;
  logic        stalled_o;
  logic        parity_o;
  logic        mmio_recv_o;
  logic        cmd_frame;
  logic        bp_en;
  logic [31:0] stim_lfsr;
  logic [31:0] bp_lfsr;
  logic [7:0]  frm_q [$];
  int          fail_cnt;
  int          tests;
  int          last_errs;
  int          errs;

  mmio_ep_top #(
    .MAX_PACKET_LENGTH (MPL),
    .FIFO_DEPTH        (FD)
  ) dut (
    .clock       (clock),
    .rst_i       (rst_i),
    .set_conf_i  (set_conf_i),
    .clr_conf_i  (clr_conf_i),
    .max_size_i  (max_size_i),
    .selected_i  (selected_i),
    .ack_sent_i  (ack_sent_i),
    .rx_error_i  (rx_error_i),
    .usb_i       (usb_i),
    .usb_ready_o (usb_ready_o),
    .cmd_o       (cmd_o),
    .cmd_vld_o   (cmd_vld_o),
    .cmd_ack_i   (cmd_ack_i),
    .mmio_sent_i (mmio_sent_i),
    .mmio_resp_i (mmio_resp_i),
    .dat_o       (dat_o),
    .dat_ready_i (dat_ready_i),
    .ep_ready_o  (ep_ready_o),
    .stalled_o   (stalled_o),
    .parity_o    (parity_o),
    .mmio_recv_o (mmio_recv_o)
  );

  mmio_ep_monitor mon (
    .clock       (clock),
    .rst_i       (rst_i),
    .cmd_frame_i (cmd_frame),
    .usb_i       (usb_i),
    .usb_ready_i (usb_ready_o),
    .cmd_i       (cmd_o),
    .cmd_vld_i   (cmd_vld_o),
    .dat_i       (dat_o),
    .dat_ready_i (dat_ready_i),
    .recv_i      (mmio_recv_o)
  );

  always #50 clock = ~clock;

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], stim_lfsr[0]};
      stim_lfsr = lfsr_next(stim_lfsr);
    end
    return r;
  endfunction

  // Expected command from the 11 frame bytes, byte k at bits 8k+7:8k
  function automatic mmio_cmd_t decode_cmd(input logic [87:0] f);
    mmio_cmd_t c;
    c.lun = f[63:60];
    c.adr = {f[59:56], f[55:48], f[47:40], f[39:32]};
    c.val = {f[79:72], f[71:64]};
    c.tag = f[87:84];
    c.dir = f[83];
    c.apb = f[82];
    c.op  = f[81:80];
    return c;
  endfunction

  // Host side back-pressure on the data stream
  always @(negedge clock) begin
    if (bp_en) begin
      dat_ready_i = bp_lfsr[0];
      bp_lfsr = lfsr_next(bp_lfsr);
    end else begin
      dat_ready_i = 1'b1;
    end
  end

  task check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_cnt++;
      $display("Fail t=%0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task timed_out(input string what);
    fail_cnt++;
    $display("Timeout at %0t waiting for %s", $time, what);
  endtask

  // Called at a falling edge, returns at the falling edge after the transfer
  task send_beat(input logic [7:0] d, input logic keep, input logic last);
    int t;
    t = 0;
    usb_i = '{valid: 1'b1, keep: keep, last: last, data: d};
    while (!usb_ready_o && t < TMO) begin
      @(negedge clock);
      t++;
    end
    if (t >= TMO) timed_out("usb_ready_o");
    @(negedge clock);
  endtask

  task send_frame();
    for (int k = 0; k < frm_q.size(); k++) begin
      send_beat(frm_q[k], 1'b1, k == frm_q.size() - 1);
    end
    usb_i.valid = 1'b0;
  endtask

  task make_cmd(input logic store, output logic [87:0] f);
    logic [3:0] tag;
    logic       apb;
    logic [1:0] op;
    logic       dir;
    f[31:0]  = MMIO_MAGIC;
    f[63:32] = rand_bits(32);
    f[79:64] = 16'(rand_bits(16));
    tag = 4'(rand_bits(4));
    apb = 1'(rand_bits(1));
    op  = store ? OP_STORE : 2'(rand_bits(2));
    // A host to device STORE is only wanted when asked for
    dir = store ? 1'b0 : ((op == OP_STORE) ? 1'b1 : 1'(rand_bits(1)));
    f[87:80] = {tag, dir, apb, op};
  endtask

  task do_cmd(input logic store);
    logic [87:0] f;
    int          t;
    make_cmd(store, f);
    mon.push_cmd(decode_cmd(f));
    frm_q.delete();
    for (int k = 0; k < 11; k++) frm_q.push_back(f[8*k +: 8]);
    cmd_frame = 1'b1;
    send_frame();
    cmd_frame = 1'b0;
    t = 0;
    while (!cmd_vld_o && t < TMO) begin
      @(negedge clock);
      t++;
    end
    if (t >= TMO) timed_out("cmd_vld_o");
    cmd_ack_i = 1'b1;
    @(negedge clock);
    cmd_ack_i = 1'b0;
    t = 0;
    while (cmd_vld_o && t < 4) begin
      @(negedge clock);
      t++;
    end
    if (cmd_vld_o) begin
      fail_cnt++;
      $display("cmd_vld_o stayed high after cmd_ack_i");
    end
    // Stand in for the MMIO master and the Bulk-In response
    if (!store) begin
      mmio_sent_i = 1'b1;
      @(negedge clock);
      mmio_sent_i = 1'b0;
      mmio_resp_i = 1'b1;
      @(negedge clock);
      mmio_resp_i = 1'b0;
    end
  endtask

  // STORE, nfull full frames, then a short frame or a ZDP
  task run_store(input int nfull, input logic zdp, input logic bp, input int drop);
    int r0;
    int t;
    int len;
    bp_en = bp;
    do_cmd(1'b1);
    r0 = mon.recv_cnt;
    for (int i = 0; i < nfull + 1; i++) begin
      len = MAXSZ;
      if (i == nfull) begin
        len = rand_bits(3);
        if (len == 0) len = 1;
      end
      frm_q.delete();
      for (int k = 0; k < len; k++) frm_q.push_back(8'(rand_bits(8)));
      if (i == nfull && zdp) begin
        send_beat(8'h00, 1'b0, 1'b1);
        usb_i.valid = 1'b0;
      end else begin
        if (i != drop) begin
          for (int k = 0; k < len; k++) mon.push_byte({k == len - 1, frm_q[k]});
        end
        send_frame();
      end
      // Receive error drops the frame, an ACK keeps it
      if (i == drop) rx_error_i = 1'b1;
      else ack_sent_i = 1'b1;
      @(negedge clock);
      rx_error_i = 1'b0;
      ack_sent_i = 1'b0;
    end
    t = 0;
    while ((mon.pending_bytes() != 0 || mon.recv_cnt == r0) && t < TMO) begin
      @(negedge clock);
      t++;
    end
    if (t >= TMO) timed_out("FIFO drain and mmio_recv_o");
    repeat (4) @(negedge clock);
    if (mon.recv_cnt != r0 + 1) begin
      fail_cnt++;
      $display("mmio_recv_o pulsed %0d times in one data phase", mon.recv_cnt - r0);
    end
    bp_en = 1'b0;
    mmio_resp_i = 1'b1;
    @(negedge clock);
    mmio_resp_i = 1'b0;
    t = 0;
    while (!usb_ready_o && t < TMO) begin
      @(negedge clock);
      t++;
    end
    if (t >= TMO) timed_out("parser back in idle");
  endtask

  // Wrong magic, 10 bytes, or 12 bytes
  task bad_frame(input int kind);
    logic [87:0] f;
    int          t;
    make_cmd(1'b0, f);
    frm_q.delete();
    for (int k = 0; k < 11; k++) frm_q.push_back(f[8*k +: 8]);
    if (kind == 0) frm_q[0] = ~frm_q[0];
    if (kind == 1) void'(frm_q.pop_back());
    if (kind == 2) frm_q.push_back(8'(rand_bits(8)));
    send_frame();
    t = 0;
    while (!stalled_o && t < 3) begin
      @(negedge clock);
      t++;
    end
    check_bit("stalled_o", 1'b1, stalled_o);
    check_bit("cmd_vld_o", 1'b0, cmd_vld_o);
    set_conf_i = 1'b1;
    @(negedge clock);
    set_conf_i = 1'b0;
    t = 0;
    while (stalled_o && t < TMO) begin
      @(negedge clock);
      t++;
    end
    if (t >= TMO) timed_out("stalled_o to clear");
    // The endpoint is enabled again once the stall is gone
    t = 0;
    while (!ep_ready_o && t < TMO) begin
      @(negedge clock);
      t++;
    end
    if (t >= TMO) timed_out("ep_ready_o after the stall cleared");
    do_cmd(1'b0);
  endtask

  task end_test(input string name);
    int now;
    now = mon.err_cnt + fail_cnt + dut.u_checker.fail_cnt;
    tests++;
    $display("test %0d %s: %0d error(s)", tests, name, now - last_errs);
    last_errs = now;
  endtask

  initial begin
    int t;
    logic p;
    clock = 1'b0;
    rst_i = 1'b1;
    set_conf_i = 1'b0;
    clr_conf_i = 1'b0;
    max_size_i = 7'(MAXSZ);
    selected_i = 1'b1;
    ack_sent_i = 1'b0;
    rx_error_i = 1'b0;
    usb_i = '0;
    cmd_ack_i = 1'b0;
    mmio_sent_i = 1'b0;
    mmio_resp_i = 1'b0;
    dat_ready_i = 1'b1;
    cmd_frame = 1'b0;
    bp_en = 1'b0;
    stim_lfsr = 32'h9454;
    bp_lfsr = 32'h9454;
    fail_cnt = 0;
    tests = 0;
    last_errs = 0;
    repeat (5) @(negedge clock);
    rst_i = 1'b0;
    @(negedge clock);

    check_bit("ep_ready_o", 1'b0, ep_ready_o);
    check_bit("stalled_o", 1'b0, stalled_o);
    check_bit("cmd_vld_o", 1'b0, cmd_vld_o);
    check_bit("parity_o", 1'b0, parity_o);
    check_bit("dat_o.valid", 1'b0, dat_o.valid);
    set_conf_i = 1'b1;
    @(negedge clock);
    set_conf_i = 1'b0;
    t = 0;
    while (!ep_ready_o && t < TMO) begin
      @(negedge clock);
      t++;
    end
    if (t >= TMO) timed_out("ep_ready_o after set_conf_i");
    end_test("reset and enable");

    for (int i = 0; i < 6; i++) do_cmd(1'b0);
    end_test("random commands");

    for (int k = 0; k < 3; k++) bad_frame(k);
    end_test("malformed frames");

    run_store(3, 1'b0, 1'b0, -1);
    run_store(2, 1'b1, 1'b0, -1);
    run_store(4, 1'b0, 1'b1, -1);
    end_test("store data phases");

    run_store(3, 1'b0, 1'b0, 1);
    end_test("receive error drop");

    for (int i = 0; i < 3; i++) begin
      p = parity_o;
      ack_sent_i = 1'b1;
      @(negedge clock);
      ack_sent_i = 1'b0;
      check_bit("parity_o", ~p, parity_o);
    end
    selected_i = 1'b0;
    p = parity_o;
    ack_sent_i = 1'b1;
    @(negedge clock);
    ack_sent_i = 1'b0;
    check_bit("parity_o", p, parity_o);
    selected_i = 1'b1;
    if (!parity_o) begin
      ack_sent_i = 1'b1;
      @(negedge clock);
      ack_sent_i = 1'b0;
    end
    clr_conf_i = 1'b1;
    @(negedge clock);
    clr_conf_i = 1'b0;
    t = 0;
    while (parity_o && t < 4) begin
      @(negedge clock);
      t++;
    end
    check_bit("parity_o", 1'b0, parity_o);
    end_test("data toggle");

    errs = mon.err_cnt + fail_cnt + dut.u_checker.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d", tests, mon.chk_cnt, errs);
    if (errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* bench/mmio_ep_monitor.sv */
`timescale 1ns/1ps

module mmio_ep_monitor (
  input logic                   clock,
  input logic                   rst_i,
  input logic                   cmd_frame_i,
  input mmio_ep_pkg::usb_byte_t usb_i,
  input logic                   usb_ready_i,
  input mmio_ep_pkg::mmio_cmd_t cmd_i,
  input logic                   cmd_vld_i,
  input mmio_ep_pkg::usb_byte_t dat_i,
  input logic                   dat_ready_i,
  input logic                   recv_i
);
  import mmio_ep_pkg::*;

  mmio_cmd_t  cmd_q [$];
  // Expected output bytes, last flag on top
  logic [8:0] byte_q [$];
  mmio_cmd_t  exp_c;
  logic [8:0] exp_b;
  int         age = 0;
  int         err_cnt = 0;
  int         chk_cnt = 0;
  int         recv_cnt = 0;

  task push_cmd(input mmio_cmd_t c);
    cmd_q.push_back(c);
  endtask

  task push_byte(input logic [8:0] b);
    byte_q.push_back(b);
  endtask

  function int pending_bytes();
    return byte_q.size();
  endfunction

  // Sampled on the rising edge, before the DUT registers update
  always @(posedge clock) begin
    if (rst_i) begin
      age = 0;
    end else begin
      // Cycle after the last command byte, valid not yet up
      if (age == 1) begin
        chk_cnt++;
        if (cmd_vld_i !== 1'b0) begin
          err_cnt++;
          $display("Fail t=%0t cmd_vld_o expected 0 actual %b", $time, cmd_vld_i);
        end
        age = 2;
      end else if (age == 2) begin
        chk_cnt++;
        if (cmd_q.size() == 0) begin
          err_cnt++;
          $display("Command frame ended with no expected command queued");
        end else begin
          exp_c = cmd_q.pop_front();
          if (cmd_vld_i !== 1'b1) begin
            err_cnt++;
            $display("Fail t=%0t cmd_vld_o expected 1 actual %b", $time, cmd_vld_i);
          end
          if (cmd_i !== exp_c) begin
            err_cnt++;
            $display("Fail t=%0t cmd_o expected %h actual %h", $time, exp_c, cmd_i);
          end
        end
        age = 0;
      end
      if (cmd_frame_i && usb_i.valid && usb_ready_i && usb_i.last) begin
        age = 1;
      end
      // Output bytes in commit order, every stored byte carries keep
      if (dat_i.valid && dat_ready_i) begin
        chk_cnt++;
        if (byte_q.size() == 0) begin
          err_cnt++;
          $display("Byte %h left the FIFO with nothing expected", dat_i.data);
        end else begin
          exp_b = byte_q.pop_front();
          if ({dat_i.keep, dat_i.last, dat_i.data} !== {1'b1, exp_b}) begin
            err_cnt++;
            $display("Fail t=%0t dat_o expected %h actual %h", $time, {1'b1, exp_b},
                     {dat_i.keep, dat_i.last, dat_i.data});
          end
        end
      end
      if (recv_i) begin
        recv_cnt++;
      end
    end
  end

endmodule

/* bench/mmio_ep_checker.sv */
`timescale 1ns/1ps

module mmio_ep_checker (
  input logic                   clock,
  input logic                   rst_i,
  input logic                   clear_i,
  input mmio_ep_pkg::mmio_cmd_t cmd_i,
  input logic                   cmd_vld_i,
  input logic                   recv_i,
  input logic                   stalled_i
);
  import mmio_ep_pkg::*;

  // Failed assertions, read back by the testbench
  int fail_cnt = 0;

  // Command fields hold while the command is offered
  a_cmd_stable: assert property (@(posedge clock) disable iff (rst_i)
    cmd_vld_i |=> !cmd_vld_i || $stable(cmd_i))
    else begin
      fail_cnt++;
      $error("cmd_o changed while cmd_vld_o was high");
    end

  // End of data phase is a single cycle strobe
  a_recv_pulse: assert property (@(posedge clock) disable iff (rst_i)
    recv_i |=> !recv_i)
    else begin
      fail_cnt++;
      $error("mmio_recv_o high for two cycles");
    end

  // Only a configuration change releases a stall
  a_stall_sticky: assert property (@(posedge clock) disable iff (rst_i)
    stalled_i && !clear_i |=> stalled_i)
    else begin
      fail_cnt++;
      $error("stalled_o dropped without a clear");
    end

endmodule

bind mmio_ep_top mmio_ep_checker u_checker (
  .clock     (clock),
  .rst_i     (rst_i),
  .clear_i   (clear_w),
  .cmd_i     (cmd_o),
  .cmd_vld_i (cmd_vld_o),
  .recv_i    (mmio_recv_o),
  .stalled_i (stalled_o)
);

/* source/mmio_ep_top.sv */
`timescale 1ns/1ps

module mmio_ep_top #(
  parameter int  MAX_PACKET_LENGTH = 64,
  parameter int  FIFO_DEPTH        = 256,
  localparam int CW                = $clog2(MAX_PACKET_LENGTH + 1),
  localparam int LW                = $clog2(FIFO_DEPTH) + 1
) (
  input  logic                   clock,
  input  logic                   rst_i,
  input  logic                   set_conf_i,
  input  logic                   clr_conf_i,
  input  logic [CW-1:0]          max_size_i,
  input  logic                   selected_i,
  input  logic                   ack_sent_i,
  input  logic                   rx_error_i,
  input  mmio_ep_pkg::usb_byte_t usb_i,
  output logic                   usb_ready_o,
  output mmio_ep_pkg::mmio_cmd_t cmd_o,
  output logic                   cmd_vld_o,
  input  logic                   cmd_ack_i,
  input  logic                   mmio_sent_i,
  input  logic                   mmio_resp_i,
  output mmio_ep_pkg::usb_byte_t dat_o,
  input  logic                   dat_ready_i,
  output logic                   ep_ready_o,
  output logic                   stalled_o,
  output logic                   parity_o,
  output logic                   mmio_recv_o
);
  import mmio_ep_pkg::*;

  usb_byte_t     fifo_in_w;
  logic          clear_w;
  logic          fifo_rst_w;
  logic          bypass_w;
  logic          beat_w;
  logic          last_w;
  logic          keep_w;
  logic          fail_w;
  logic          xfer_end_w;
  logic          parse_ready_w;
  logic          fifo_ready_w;
  logic [LW-1:0] level_w;

  // Stream goes to the FIFO only during a data phase
  assign usb_ready_o = bypass_w ? fifo_ready_w : parse_ready_w;

  always_comb begin
    fifo_in_w       = usb_i;
    fifo_in_w.valid = usb_i.valid && bypass_w;
  end

  cbw_parser u_parser (
    .clock        (clock),
    .rst_i        (rst_i),
    .clear_i      (clear_w),
    .stall_i      (stalled_o),
    .selected_i   (selected_i),
    .usb_i        (usb_i),
    .fifo_ready_i (fifo_ready_w),
    .xfer_end_i   (xfer_end_w),
    .cmd_ack_i    (cmd_ack_i),
    .mmio_resp_i  (mmio_resp_i),
    .usb_ready_o  (parse_ready_w),
    .cmd_o        (cmd_o),
    .cmd_vld_o    (cmd_vld_o),
    .bypass_o     (bypass_w),
    .beat_o       (beat_w),
    .last_o       (last_w),
    .keep_o       (keep_w),
    .fail_o       (fail_w)
  );

  ep_control #(
    .MAX_PACKET_LENGTH (MAX_PACKET_LENGTH),
    .FIFO_DEPTH        (FIFO_DEPTH)
  ) u_control (
    .clock       (clock),
    .rst_i       (rst_i),
    .set_conf_i  (set_conf_i),
    .clr_conf_i  (clr_conf_i),
    .max_size_i  (max_size_i),
    .selected_i  (selected_i),
    .ack_sent_i  (ack_sent_i),
    .vld_i       (cmd_vld_o),
    .bypass_i    (bypass_w),
    .beat_i      (beat_w),
    .last_i      (last_w),
    .keep_i      (keep_w),
    .fail_i      (fail_w),
    .level_i     (level_w),
    .mmio_sent_i (mmio_sent_i),
    .mmio_resp_i (mmio_resp_i),
    .clear_o     (clear_w),
    .stall_o     (stalled_o),
    .fifo_rst_o  (fifo_rst_w),
    .ep_ready_o  (ep_ready_o),
    .parity_o    (parity_o),
    .mmio_recv_o (mmio_recv_o),
    .xfer_end_o  (xfer_end_w)
  );

  // Commit on the controller ACK, rewind on a receive error
  bulk_packet_fifo #(
    .DEPTH             (FIFO_DEPTH),
    .MAX_PACKET_LENGTH (MAX_PACKET_LENGTH)
  ) u_fifo (
    .clock     (clock),
    .rst_i     (fifo_rst_w),
    .drop_i    (rx_error_i),
    .save_i    (ack_sent_i),
    .s_i       (fifo_in_w),
    .s_ready_o (fifo_ready_w),
    .m_o       (dat_o),
    .m_ready_i (dat_ready_i),
    .level_o   (level_w)
  );

endmodule

/* source/ep_control.sv */
`timescale 1ns/1ps

module ep_control #(
  parameter int  MAX_PACKET_LENGTH = 64,
  parameter int  FIFO_DEPTH        = 256,
  localparam int CW                = $clog2(MAX_PACKET_LENGTH + 1),
  localparam int LW                = $clog2(FIFO_DEPTH) + 1
) (
  input  logic          clock,
  input  logic          rst_i,
  input  logic          set_conf_i,
  input  logic          clr_conf_i,
  input  logic [CW-1:0] max_size_i,
  input  logic          selected_i,
  input  logic          ack_sent_i,
  input  logic          vld_i,
  input  logic          bypass_i,
  input  logic          beat_i,
  input  logic          last_i,
  input  logic          keep_i,
  input  logic          fail_i,
  input  logic [LW-1:0] level_i,
  input  logic          mmio_sent_i,
  input  logic          mmio_resp_i,
  output logic          clear_o,
  output logic          stall_o,
  output logic          fifo_rst_o,
  output logic          ep_ready_o,
  output logic          parity_o,
  output logic          mmio_recv_o,
  output logic          xfer_end_o
);
  import mmio_ep_pkg::*;

  ep_state_t     state_q;
  logic          clear_q;
  logic          en_q;
  logic          stall_q;
  logic          ready_q;
  logic          parity_q;
  logic          recvd_q;
  logic          fifo_rst_q;
  logic [CW-1:0] count_q;
  logic [LW-1:0] space_w;
  logic          end_w;

  // Config change or reset flushes the endpoint a cycle later
  always_ff @(posedge clock) begin
    clear_q <= rst_i || set_conf_i || clr_conf_i;
  end

  // Enable, a set_conf wins over a pending stall
  // The stall is still up while the clear is in flight
  always_ff @(posedge clock) begin
    if (rst_i || clr_conf_i) begin
      en_q <= 1'b0;
    end else if (set_conf_i) begin
      en_q <= 1'b1;
    end else if (stall_q && !clear_q) begin
      en_q <= 1'b0;
    end
  end

  // Stall sticks until the configuration is set or cleared
  always_ff @(posedge clock) begin
    if (rst_i || clear_q) begin
      stall_q <= 1'b0;
    end else if (fail_i) begin
      stall_q <= 1'b1;
    end
  end

  // Ready when a whole max size packet still fits
  assign space_w = LW'(FIFO_DEPTH) - level_i;

  always_ff @(posedge clock) begin
    if (rst_i || clear_q || stall_q || !en_q) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= (space_w >= max_size_i);
    end
  end

  // DATA0/DATA1 toggle on every ACK for this endpoint
  always_ff @(posedge clock) begin
    if (rst_i || clear_q) begin
      parity_q <= 1'b0;
    end else if (selected_i && ack_sent_i) begin
      parity_q <= ~parity_q;
    end
  end

  // Bytes left in the current frame, counted down from the max size
  // A frame is full only if its final byte used up the count
  assign end_w = bypass_i && beat_i && last_i &&
                 (keep_i ? (count_q != CW'(1)) : (count_q != '0));

  always_ff @(posedge clock) begin
    if (rst_i || !bypass_i) begin
      count_q <= max_size_i;
    end else if (beat_i && last_i) begin
      count_q <= max_size_i;
    end else if (beat_i && keep_i) begin
      count_q <= count_q - 1'b1;
    end
  end

  // Data phase end, at most one cycle long
  always_ff @(posedge clock) begin
    if (rst_i || clear_q) begin
      recvd_q <= 1'b0;
    end else begin
      recvd_q <= end_w && !recvd_q;
    end
  end

  // Phase FSM
  always_ff @(posedge clock) begin
    if (rst_i || clear_q) begin
      state_q <= EP_IDLE;
    end else if (stall_q) begin
      state_q <= EP_HALT;
    end else begin
      case (state_q)
        EP_IDLE: if (vld_i) state_q <= EP_XFER;
        EP_XFER: if (mmio_sent_i || recvd_q) state_q <= EP_RESP;
        EP_RESP: if (mmio_resp_i) state_q <= EP_IDLE;
        default: state_q <= EP_HALT;
      endcase
    end
  end

  // FIFO released by a STORE, kept alive to drain until the response
  always_ff @(posedge clock) begin
    if (rst_i || clear_q || mmio_resp_i || state_q == EP_HALT) begin
      fifo_rst_q <= 1'b1;
    end else if (bypass_i) begin
      fifo_rst_q <= 1'b0;
    end
  end

  assign clear_o     = clear_q;
  assign stall_o     = stall_q;
  assign fifo_rst_o  = fifo_rst_q;
  assign ep_ready_o  = ready_q;
  assign parity_o    = parity_q;
  assign mmio_recv_o = recvd_q;
  assign xfer_end_o  = recvd_q;

endmodule

/* source/bulk_packet_fifo.sv */
`timescale 1ns/1ps

module bulk_packet_fifo #(
  parameter int  DEPTH             = 256,
  parameter int  MAX_PACKET_LENGTH = 64,
  localparam int AW                = $clog2(DEPTH),
  localparam int FW                = $clog2(MAX_PACKET_LENGTH + 1)
) (
  input  logic                   clock,
  input  logic                   rst_i,
  input  logic                   drop_i,
  input  logic                   save_i,
  input  mmio_ep_pkg::usb_byte_t s_i,
  output logic                   s_ready_o,
  output mmio_ep_pkg::usb_byte_t m_o,
  input  logic                   m_ready_i,
  output logic [AW:0]            level_o
);
  import mmio_ep_pkg::*;

  logic [7:0]    mem_q [DEPTH];
  logic          lst_q [DEPTH];
  usb_byte_t     out_q;
  // Provisional write, committed and read pointers, one wrap bit each
  logic [AW:0]   wr_q;
  logic [AW:0]   cm_q;
  logic [AW:0]   rd_q;
  logic [AW:0]   wr_nx_w;
  logic [AW:0]   rd_nx_w;
  logic [FW-1:0] flen_q;
  logic          bab_q;
  logic          ready_q;
  logic          wr_w;
  logic          pop_w;
  logic          keep_frame_w;

  // ZDP beats and empty last beats carry nothing to store
  assign wr_w  = s_i.valid && ready_q && s_i.keep;
  // Only committed bytes may be read
  assign pop_w = (rd_q != cm_q) && (!out_q.valid || m_ready_i);
  // Overlong frames are thrown away on save
  assign keep_frame_w = save_i && !bab_q && !drop_i;

  always_comb begin
    if (drop_i || (save_i && bab_q)) begin
      wr_nx_w = cm_q;
    end else begin
      wr_nx_w = wr_q + (AW + 1)'(wr_w);
    end
    rd_nx_w = rd_q + (AW + 1)'(pop_w);
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      wr_q    <= '0;
      cm_q    <= '0;
      rd_q    <= '0;
      flen_q  <= '0;
      bab_q   <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      wr_q <= wr_nx_w;
      rd_q <= rd_nx_w;
      // A byte written alongside the save belongs to the next frame
      if (keep_frame_w) begin
        cm_q <= wr_q;
      end
      // Frame length guard
      if (save_i || drop_i) begin
        flen_q <= '0;
        bab_q  <= 1'b0;
      end else if (wr_w) begin
        if (flen_q == FW'(MAX_PACKET_LENGTH)) begin
          bab_q <= 1'b1;
        end else begin
          flen_q <= flen_q + 1'b1;
        end
      end
      // Ready from the fill after this edge, so a full FIFO never takes a byte
      ready_q <= (wr_nx_w - rd_nx_w) != (AW + 1)'(DEPTH);
    end
  end

  // Storage, last kept per byte
  always_ff @(posedge clock) begin
    if (wr_w) begin
      mem_q[wr_q[AW-1:0]] <= s_i.data;
      lst_q[wr_q[AW-1:0]] <= s_i.last;
    end
    // Mark the final stored byte on commit, covers a last beat without data
    if (keep_frame_w && wr_q != cm_q) begin
      lst_q[wr_q[AW-1:0] - 1'b1] <= 1'b1;
    end
  end

  // Output register, refilled whenever it empties or is taken
  always_ff @(posedge clock) begin
    if (pop_w) begin
      out_q.valid <= 1'b1;
      out_q.keep  <= 1'b1;
      out_q.last  <= lst_q[rd_q[AW-1:0]];
      out_q.data  <= mem_q[rd_q[AW-1:0]];
    end else if (m_ready_i) begin
      out_q.valid <= 1'b0;
    end
    if (rst_i) begin
      out_q.valid <= 1'b0;
    end
  end

  assign s_ready_o = ready_q;
  assign m_o       = out_q;
  // Counts provisional bytes too, they take space all the same
  assign level_o   = wr_q - rd_q;

endmodule

/* source/cbw_parser.sv */
`timescale 1ns/1ps

module cbw_parser (
  input  logic                   clock,
  input  logic                   rst_i,
  input  logic                   clear_i,
  input  logic                   stall_i,
  input  logic                   selected_i,
  input  mmio_ep_pkg::usb_byte_t usb_i,
  input  logic                   fifo_ready_i,
  input  logic                   xfer_end_i,
  input  logic                   cmd_ack_i,
  input  logic                   mmio_resp_i,
  output logic                   usb_ready_o,
  output mmio_ep_pkg::mmio_cmd_t cmd_o,
  output logic                   cmd_vld_o,
  output logic                   bypass_o,
  output logic                   beat_o,
  output logic                   last_o,
  output logic                   keep_o,
  output logic                   fail_o
);
  import mmio_ep_pkg::*;

  parse_state_t state_q;
  mmio_cmd_t    cmd_q;
  logic         flush_w;
  logic         take_w;
  logic         idop_ok_w;
  logic         beat_q;
  logic         keep_q;
  logic         last_q;
  logic         vld_q;
  logic         bypass_q;
  logic [31:0]  dat_q;
  logic [1:0]   sel_q;

  assign flush_w = rst_i || clear_i;

  // Bytes are taken while a frame is being parsed, or a bad one swallowed
  // Hold off for the cycle after a last byte until the state catches up
  assign usb_ready_o = selected_i && (state_q != PS_BUSY) && !(beat_q && last_q);

  // During a data phase the FIFO decides when a beat moves
  assign take_w = usb_i.valid && (bypass_q ? fifo_ready_i : usb_ready_o);

  // Final byte of a well formed command
  assign idop_ok_w = (state_q == PS_IDOP) && beat_q && keep_q && last_q;

  // Beat pipeline register
  always_ff @(posedge clock) begin
    if (flush_w) begin
      beat_q <= 1'b0;
      keep_q <= 1'b0;
      last_q <= 1'b0;
      sel_q  <= 2'd0;
    end else begin
      beat_q <= take_w;
      keep_q <= take_w && usb_i.keep;
      last_q <= take_w && usb_i.last;
      // Byte selector, restarts with every frame
      if (take_w && usb_i.last) begin
        sel_q <= 2'd0;
      end else if (take_w && usb_i.keep) begin
        sel_q <= sel_q + 2'd1;
      end
    end
  end

  // Bytes enter at the top, so a full word has its first byte lowest
  always_ff @(posedge clock) begin
    if (take_w && usb_i.keep) begin
      dat_q <= {usb_i.data, dat_q[31:8]};
    end
  end

  // Parser FSM
  // Every step checks for an early end before looking at the selector
  always_ff @(posedge clock) begin
    if (flush_w) begin
      state_q <= PS_IDLE;
    end else begin
      case (state_q)
        PS_IDLE: begin
          // Magic word checked once four bytes are in
          if (beat_q && (last_q || !keep_q)) begin
            state_q <= PS_FAIL;
          end else if (beat_q && sel_q == 2'd0) begin
            state_q <= (dat_q == MMIO_MAGIC) ? PS_ADDR : PS_FAIL;
          end
        end
        PS_ADDR: begin
          if (beat_q && (last_q || !keep_q)) begin
            state_q <= PS_FAIL;
          end else if (beat_q && sel_q == 2'd0) begin
            state_q <= PS_WORD;
          end
        end
        PS_WORD: begin
          if (beat_q && (last_q || !keep_q)) begin
            state_q <= PS_FAIL;
          end else if (beat_q && sel_q == 2'd2) begin
            state_q <= PS_IDOP;
          end
        end
        PS_IDOP: begin
          // 11th byte must carry last, anything else is an overlong frame
          if (idop_ok_w) begin
            state_q <= PS_BUSY;
          end else if (beat_q) begin
            state_q <= PS_FAIL;
          end
        end
        PS_BUSY: begin
          // Back to idle once the command is taken and any data phase is over
          if (!vld_q && !bypass_q) begin
            state_q <= PS_IDLE;
          end
        end
        default: begin
          // FAIL waits for a clear from the control pipe
          state_q <= PS_FAIL;
        end
      endcase
    end
  end

  // Field capture, only ever written before vld goes high
  always_ff @(posedge clock) begin
    if (beat_q && keep_q && !last_q) begin
      if (state_q == PS_ADDR && sel_q == 2'd0) begin
        {cmd_q.lun, cmd_q.adr} <= dat_q;
      end
      // Two value bytes sit in the upper half
      if (state_q == PS_WORD && sel_q == 2'd2) begin
        cmd_q.val <= dat_q[31:16];
      end
    end
    if (idop_ok_w) begin
      {cmd_q.tag, cmd_q.dir, cmd_q.apb, cmd_q.op} <= dat_q[31:24];
    end
  end

  // Command valid, held until taken or answered
  always_ff @(posedge clock) begin
    if (flush_w || stall_i) begin
      vld_q <= 1'b0;
    end else if (idop_ok_w) begin
      vld_q <= 1'b1;
    end else if (cmd_ack_i || mmio_resp_i) begin
      vld_q <= 1'b0;
    end
  end

  // Bypass routes the stream into the FIFO for a host to device STORE
  // Bit 27 is dir, bits 25:24 the op
  always_ff @(posedge clock) begin
    if (flush_w || stall_i) begin
      bypass_q <= 1'b0;
    end else if (idop_ok_w) begin
      bypass_q <= (dat_q[25:24] == OP_STORE) && !dat_q[27];
    end else if (xfer_end_i) begin
      bypass_q <= 1'b0;
    end
  end

  assign cmd_o     = cmd_q;
  assign cmd_vld_o = vld_q;
  assign bypass_o  = bypass_q;
  assign beat_o    = beat_q;
  assign last_o    = last_q;
  assign keep_o    = keep_q;
  assign fail_o    = (state_q == PS_FAIL);

endmodule

/* source/mmio_ep_pkg.sv */
package mmio_ep_pkg;

  // One byte beat of a USB Bulk-Out stream
  // A ZDP is a beat with last set and keep clear
  typedef struct packed {
    logic       valid;
    logic       keep;
    logic       last;
    logic [7:0] data;
  } usb_byte_t;

  // Decoded MMIO command, 56 bits
  // Field order follows the frame byte order from the top down
  typedef struct packed {
    logic [3:0]  lun;
    logic [27:0] adr;
    // Transfer length, or a 16-bit value for an APB access
    logic [15:0] val;
    logic [3:0]  tag;
    // Set for device to host
    logic        dir;
    logic        apb;
    logic [1:0]  op;
  } mmio_cmd_t;

  // Parser states, one-hot
  typedef enum logic [5:0] {
    PS_IDLE = 6'b000001,
    PS_ADDR = 6'b000010,
    PS_WORD = 6'b000100,
    PS_IDOP = 6'b001000,
    PS_BUSY = 6'b010000,
    PS_FAIL = 6'b100000
  } parse_state_t;

  // Endpoint phase states, one-hot
  typedef enum logic [3:0] {
    EP_IDLE = 4'b0001,
    EP_XFER = 4'b0010,
    EP_RESP = 4'b0100,
    EP_HALT = 4'b1000
  } ep_state_t;

  // Frame magic, "TRAT" read as a word with the first byte lowest
  localparam logic [31:0] MMIO_MAGIC = 32'h5441_5254;

  // STORE with dir clear is the only command followed by a data phase
  localparam logic [1:0] OP_STORE = 2'd0;

endpackage
